//--- flist.f
rtl/mmu_pkg.sv
rtl/tlb_cmd_pkg.sv
rtl/tlb_init_seq.sv
rtl/tlb_ram.sv
rtl/tlb_lookup.sv
rtl/tlb_req_port.sv
rtl/tlb_unit.sv
sim/tlb_unit_tb.sv

//--- rtl/mmu_pkg.sv
`default_nettype none

// ==================================================
// TLB geometry and entry format
// ==================================================

package mmu_pkg;

	// Address split: tag | set | page offset
	localparam int ADDR_W = 32;
	localparam int PAGE_W = 13;
	localparam int VPN_W = ADDR_W - PAGE_W;
	localparam int PPN_W = 19;

	// Sixteen sets of four ways
	localparam int SETS = 16;
	localparam int WAYS = 4;
	localparam int SET_W = $clog2(SETS);
	localparam int WAY_W = $clog2(WAYS);

	// The tag is what is left of the VPN once the set index is taken off
	localparam int TAG_W = VPN_W - SET_W;

	// ==================================================
	// Boot map
	// ==================================================

	// The ROM window sits at the top of the address space
	localparam logic [ADDR_W-1:0] ROM_BASE_ADDR = 32'hFFF0_0000;

	// First ROM page number, its low set bits are zero so set n maps page base+n
	localparam logic [VPN_W-1:0] ROM_VPN_BASE = ROM_BASE_ADDR[ADDR_W-1:PAGE_W];

	// ROM pages are readable and executable but never writable
	localparam logic [2:0] ROM_RWX = 3'b101;

	// One TLB entry, 39 bits
	typedef struct packed {
		logic v;
		logic lock;
		logic [2:0] rwx;
		logic [TAG_W-1:0] tag;
		logic [PPN_W-1:0] ppn;
	} tlb_entry_t;

	// A whole set is read at once by the lookup
	typedef tlb_entry_t [WAYS-1:0] tlb_set_t;

endpackage

`default_nettype wire

//--- rtl/tlb_cmd_pkg.sv
`default_nettype none

// ==================================================
// Host port commands and responses
// ==================================================

package tlb_cmd_pkg;

	// Commands the host may send
	typedef enum logic [1:0] {
		OP_XLATE,
		OP_WRITE,
		OP_FLUSH
	} opcode_e;

	// Outcome returned with ack
	typedef enum logic [1:0] {
		ST_HIT,
		ST_MISS,
		ST_DONE,
		ST_DENIED
	} status_e;

	// The ppn, rwx and way fields only matter for OP_WRITE
	typedef struct packed {
		opcode_e op;
		logic [mmu_pkg::ADDR_W-1:0] vaddr;
		logic [mmu_pkg::PPN_W-1:0] ppn;
		logic [2:0] rwx;
		logic [mmu_pkg::WAY_W-1:0] way;
	} tlb_cmd_t;

	// Way is the hit way on a translate or the target way on a write
	typedef struct packed {
		status_e status;
		logic [mmu_pkg::ADDR_W-1:0] paddr;
		logic [2:0] rwx;
		logic [mmu_pkg::WAY_W-1:0] way;
	} tlb_resp_t;

endpackage

`default_nettype wire

//--- rtl/tlb_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_init_seq
(
	input wire logic clk,
	input wire logic rst,
	input wire logic flush_trig,
	output logic fill_busy,
	output logic fill_we,
	output logic [mmu_pkg::SET_W-1:0] fill_set,
	output logic [mmu_pkg::WAY_W-1:0] fill_way,
	output mmu_pkg::tlb_entry_t fill_entry
);

	typedef enum logic {
		INIT_FILL,
		INIT_IDLE
	} init_state_e;

	init_state_e state;

	// Way runs in the low bits so a set is finished before the next one starts
	logic [mmu_pkg::SET_W+mmu_pkg::WAY_W-1:0] cnt;
	logic [mmu_pkg::VPN_W-1:0] boot_vpn;

	// Reset lands in the fill state, so the map is rebuilt before any command
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= INIT_FILL;
			cnt <= '0;
		end
		else if (state == INIT_FILL)
		begin
			cnt <= cnt + 1'b1;
			// All 64 entries are written once the counter is all ones
			if (&cnt)
				state <= INIT_IDLE;
		end
		else if (flush_trig)
		begin
			state <= INIT_FILL;
			cnt <= '0;
		end
	end

	assign fill_busy = (state == INIT_FILL);
	assign fill_we = (state == INIT_FILL);
	assign fill_set = cnt[mmu_pkg::WAY_W +: mmu_pkg::SET_W];
	assign fill_way = cnt[mmu_pkg::WAY_W-1:0];

	// Set n holds the ROM page base+n, the base has zero set bits
	assign boot_vpn = mmu_pkg::ROM_VPN_BASE
		| {{(mmu_pkg::VPN_W-mmu_pkg::SET_W){1'b0}}, fill_set};

	always_comb
	begin
		fill_entry = '0;
		// Only way 0 carries a mapping, identity mapped and locked
		if (fill_way == '0)
		begin
			fill_entry.v = 1'b1;
			fill_entry.lock = 1'b1;
			fill_entry.rwx = mmu_pkg::ROM_RWX;
			fill_entry.tag = boot_vpn[mmu_pkg::VPN_W-1:mmu_pkg::SET_W];
			fill_entry.ppn = boot_vpn;
		end
	end

	// The port must wait for the fill to end before it asks for another one
	a_flush_when_idle: assert property (
		@(posedge clk) disable iff (rst)
		flush_trig |-> !fill_busy
	);

endmodule

`default_nettype wire

//--- rtl/tlb_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup
(
	input wire logic clk,
	input wire logic rst,
	input wire logic iss_valid,
	input wire tlb_cmd_pkg::tlb_cmd_t iss_cmd,
	output logic [mmu_pkg::SET_W-1:0] rd_set,
	input wire mmu_pkg::tlb_set_t rd_data,
	output logic host_we,
	output logic [mmu_pkg::SET_W-1:0] host_set,
	output logic [mmu_pkg::WAY_W-1:0] host_way,
	output mmu_pkg::tlb_entry_t host_entry,
	output logic rsp_valid,
	output tlb_cmd_pkg::tlb_resp_t rsp
);

	// Command riding alongside the set read
	logic s1_valid;
	tlb_cmd_pkg::tlb_cmd_t s1_cmd;

	logic [mmu_pkg::TAG_W-1:0] s1_tag;
	logic [mmu_pkg::PAGE_W-1:0] s1_off;
	logic hit;
	logic [mmu_pkg::WAY_W-1:0] hit_way;
	logic wr_ok;
	tlb_cmd_pkg::tlb_resp_t rsp_d;

	// The set index goes straight to the RAM, whose read is registered
	assign rd_set = iss_cmd.vaddr[mmu_pkg::PAGE_W +: mmu_pkg::SET_W];

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= iss_valid;
		s1_cmd <= iss_cmd;
	end

	// ==================================================
	// Compare stage
	// ==================================================

	assign s1_tag = s1_cmd.vaddr[mmu_pkg::PAGE_W+mmu_pkg::SET_W +: mmu_pkg::TAG_W];
	assign s1_off = s1_cmd.vaddr[mmu_pkg::PAGE_W-1:0];

	// The lowest matching way wins, a correct map has at most one match
	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = mmu_pkg::WAYS - 1; w >= 0; w--)
		begin
			if (rd_data[w].v && rd_data[w].tag == s1_tag)
			begin
				hit = 1'b1;
				hit_way = w[mmu_pkg::WAY_W-1:0];
			end
		end
	end

	// Locked entries belong to the boot map and refuse host writes
	assign wr_ok = !rd_data[s1_cmd.way].lock;

	assign host_we = s1_valid && s1_cmd.op == tlb_cmd_pkg::OP_WRITE && wr_ok;
	assign host_set = s1_cmd.vaddr[mmu_pkg::PAGE_W +: mmu_pkg::SET_W];
	assign host_way = s1_cmd.way;

	// Host entries are always valid and never locked
	always_comb
	begin
		host_entry.v = 1'b1;
		host_entry.lock = 1'b0;
		host_entry.rwx = s1_cmd.rwx;
		host_entry.tag = s1_tag;
		host_entry.ppn = s1_cmd.ppn;
	end

	always_comb
	begin
		rsp_d = '0;
		rsp_d.status = tlb_cmd_pkg::ST_MISS;
		if (s1_cmd.op == tlb_cmd_pkg::OP_WRITE)
		begin
			rsp_d.way = s1_cmd.way;
			rsp_d.status = wr_ok ? tlb_cmd_pkg::ST_DONE : tlb_cmd_pkg::ST_DENIED;
			if (wr_ok)
			begin
				rsp_d.paddr = {s1_cmd.ppn, s1_off};
				rsp_d.rwx = s1_cmd.rwx;
			end
		end
		else if (hit)
		begin
			rsp_d.status = tlb_cmd_pkg::ST_HIT;
			rsp_d.paddr = {rd_data[hit_way].ppn, s1_off};
			rsp_d.rwx = rd_data[hit_way].rwx;
			rsp_d.way = hit_way;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= s1_valid;
		rsp <= rsp_d;
	end

endmodule

`default_nettype wire

//--- rtl/tlb_ram.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_ram
(
	input wire logic clk,
	input wire logic rst,
	input wire logic [mmu_pkg::SET_W-1:0] rd_set,
	output mmu_pkg::tlb_set_t rd_data,
	input wire logic fill_we,
	input wire logic [mmu_pkg::SET_W-1:0] fill_set,
	input wire logic [mmu_pkg::WAY_W-1:0] fill_way,
	input wire mmu_pkg::tlb_entry_t fill_entry,
	input wire logic host_we,
	input wire logic [mmu_pkg::SET_W-1:0] host_set,
	input wire logic [mmu_pkg::WAY_W-1:0] host_way,
	input wire mmu_pkg::tlb_entry_t host_entry
);

	// One row per set, each row is all four ways side by side
	mmu_pkg::tlb_set_t mem [mmu_pkg::SETS];

	logic wr_en;
	logic [mmu_pkg::SET_W-1:0] wr_set;
	logic [mmu_pkg::WAY_W-1:0] wr_way;
	mmu_pkg::tlb_entry_t wr_entry;

	// ==================================================
	// Write mux
	// ==================================================

	// The fill machine wins, host writes are only possible once it is idle
	always_comb
	begin
		wr_en = fill_we | host_we;
		if (fill_we)
		begin
			wr_set = fill_set;
			wr_way = fill_way;
			wr_entry = fill_entry;
		end
		else
		begin
			wr_set = host_set;
			wr_way = host_way;
			wr_entry = host_entry;
		end
	end

	// A read of the set being written returns the old contents
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_set][wr_way] <= wr_entry;
		rd_data <= mem[rd_set];
	end

	// Host writes come from the lookup and must never overlap a fill
	a_one_writer: assert property (
		@(posedge clk) disable iff (rst)
		!(fill_we && host_we)
	);

endmodule

`default_nettype wire

//--- rtl/tlb_req_port.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_req_port
(
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire tlb_cmd_pkg::tlb_cmd_t cmd,
	output logic ack,
	output tlb_cmd_pkg::tlb_resp_t resp,
	input wire logic fill_busy,
	output logic flush_trig,
	output logic iss_valid,
	output tlb_cmd_pkg::tlb_cmd_t iss_cmd,
	input wire logic rsp_valid,
	input wire tlb_cmd_pkg::tlb_resp_t rsp
);

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_WAIT_RSP,
		PORT_WAIT_FILL,
		PORT_ACK
	} port_state_e;

	port_state_e state;

	// ==================================================
	// Handshake FSM
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= PORT_IDLE;
			ack <= 1'b0;
			flush_trig <= 1'b0;
			iss_valid <= 1'b0;
		end
		else
		begin
			// Both triggers are single cycle pulses
			iss_valid <= 1'b0;
			flush_trig <= 1'b0;
			case (state)
			PORT_IDLE:
				// Ack is low here, so a high req is always a fresh command
				if (req && !fill_busy)
				begin
					if (cmd.op == tlb_cmd_pkg::OP_FLUSH)
					begin
						flush_trig <= 1'b1;
						state <= PORT_WAIT_FILL;
					end
					else
					begin
						iss_valid <= 1'b1;
						state <= PORT_WAIT_RSP;
					end
				end
			PORT_WAIT_RSP:
				if (rsp_valid)
				begin
					ack <= 1'b1;
					state <= PORT_ACK;
				end
			PORT_WAIT_FILL:
				// Fill busy only rises the cycle after the trigger, so skip that cycle
				if (!flush_trig && !fill_busy)
				begin
					ack <= 1'b1;
					state <= PORT_ACK;
				end
			PORT_ACK:
				if (!req)
				begin
					ack <= 1'b0;
					state <= PORT_IDLE;
				end
			default:
				state <= PORT_IDLE;
			endcase
		end
	end

	// The command and response registers are loaded once per handshake
	always_ff @(posedge clk)
	begin
		if (state == PORT_IDLE && req)
			iss_cmd <= cmd;
		if (state == PORT_WAIT_RSP && rsp_valid)
			resp <= rsp;
		else if (state == PORT_WAIT_FILL)
		begin
			resp <= '0;
			resp.status <= tlb_cmd_pkg::ST_DONE;
		end
	end

	// The host keeps req up until it has seen ack
	a_req_held_for_ack: assert property (
		@(posedge clk) disable iff (rst)
		$fell(req) |-> $past(ack)
	);

endmodule

`default_nettype wire

//--- rtl/tlb_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_unit
(
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire tlb_cmd_pkg::tlb_cmd_t cmd,
	output logic ack,
	output tlb_cmd_pkg::tlb_resp_t resp
);

	// Port to lookup
	logic iss_valid;
	tlb_cmd_pkg::tlb_cmd_t iss_cmd;
	logic rsp_valid;
	tlb_cmd_pkg::tlb_resp_t rsp;

	// Lookup to RAM
	logic [mmu_pkg::SET_W-1:0] rd_set;
	mmu_pkg::tlb_set_t rd_data;
	logic host_we;
	logic [mmu_pkg::SET_W-1:0] host_set;
	logic [mmu_pkg::WAY_W-1:0] host_way;
	mmu_pkg::tlb_entry_t host_entry;

	// Fill machine channel
	logic flush_trig;
	logic fill_busy;
	logic fill_we;
	logic [mmu_pkg::SET_W-1:0] fill_set;
	logic [mmu_pkg::WAY_W-1:0] fill_way;
	mmu_pkg::tlb_entry_t fill_entry;

	tlb_req_port u_port (.clk, .rst, .req, .cmd, .ack, .resp, .fill_busy,
		.flush_trig, .iss_valid, .iss_cmd, .rsp_valid, .rsp);

	tlb_lookup u_lookup (.clk, .rst, .iss_valid, .iss_cmd, .rd_set, .rd_data,
		.host_we, .host_set, .host_way, .host_entry, .rsp_valid, .rsp);

	tlb_ram u_ram (.clk, .rst, .rd_set, .rd_data, .fill_we, .fill_set, .fill_way,
		.fill_entry, .host_we, .host_set, .host_way, .host_entry);

	// Sits beside the pipeline and owns the RAM while it rebuilds the map
	tlb_init_seq u_init (.clk, .rst, .flush_trig, .fill_busy, .fill_we, .fill_set,
		.fill_way, .fill_entry);

endmodule

`default_nettype wire

//--- sim/tlb_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_unit_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	// Extra cycles the host keeps req high after ack has risen
	localparam int HOLD_CYCLES = 3;
	localparam int NUM_STEPS = 18;

	// One table row holds the command and what the host expects to see back
	typedef struct packed {
		tlb_cmd_pkg::tlb_cmd_t cmd;
		tlb_cmd_pkg::status_e exp_status;
		logic chk_paddr;
		logic [31:0] exp_paddr;
	} step_t;

	logic clk;
	logic rst;
	logic req;
	tlb_cmd_pkg::tlb_cmd_t cmd;
	logic ack;
	tlb_cmd_pkg::tlb_resp_t resp;

	step_t steps [NUM_STEPS];
	string names [NUM_STEPS];

	// Expected contents of every set and way
	mmu_pkg::tlb_entry_t model [mmu_pkg::SETS][mmu_pkg::WAYS];

	int pass_count;
	int fail_count;
	int step_errors;

	tlb_unit uut (.clk, .rst, .req, .cmd, .ack, .resp);

	always #(CLK_PERIOD/2) clk = ~clk;

	// ==================================================
	// Reference model
	// ==================================================

	// Way 0 of set s maps ROM page base+s onto itself and all other ways are empty
	function automatic void load_boot_map();
		logic [mmu_pkg::VPN_W-1:0] vpn;
		for (int s = 0; s < mmu_pkg::SETS; s++)
		begin
			for (int w = 0; w < mmu_pkg::WAYS; w++)
				model[s][w] = '0;
			vpn = mmu_pkg::ROM_VPN_BASE + s[mmu_pkg::VPN_W-1:0];
			model[s][0].v = 1'b1;
			model[s][0].lock = 1'b1;
			model[s][0].rwx = 3'b101;
			model[s][0].tag = vpn[18:4];
			model[s][0].ppn = vpn;
		end
	endfunction

	// Works out the response to one command and applies its effect on the model
	function automatic tlb_cmd_pkg::tlb_resp_t predict(input tlb_cmd_pkg::tlb_cmd_t c);
		tlb_cmd_pkg::tlb_resp_t r;
		logic [3:0] set_idx;
		logic [14:0] tag;
		logic [12:0] off;
		logic found;
		r = '0;
		found = 1'b0;
		// 8 KiB pages and 16 sets split the address as tag | set | offset
		set_idx = c.vaddr[16:13];
		tag = c.vaddr[31:17];
		off = c.vaddr[12:0];
		case (c.op)
		tlb_cmd_pkg::OP_XLATE:
		begin
			r.status = tlb_cmd_pkg::ST_MISS;
			for (int w = 0; w < mmu_pkg::WAYS; w++)
			begin
				if (!found && model[set_idx][w].v && model[set_idx][w].tag == tag)
				begin
					found = 1'b1;
					r.status = tlb_cmd_pkg::ST_HIT;
					r.paddr = {model[set_idx][w].ppn, off};
					r.rwx = model[set_idx][w].rwx;
					r.way = w[1:0];
				end
			end
		end
		tlb_cmd_pkg::OP_WRITE:
		begin
			r.way = c.way;
			if (model[set_idx][c.way].lock)
				r.status = tlb_cmd_pkg::ST_DENIED;
			else
			begin
				r.status = tlb_cmd_pkg::ST_DONE;
				r.paddr = {c.ppn, off};
				r.rwx = c.rwx;
				model[set_idx][c.way].v = 1'b1;
				model[set_idx][c.way].lock = 1'b0;
				model[set_idx][c.way].rwx = c.rwx;
				model[set_idx][c.way].tag = tag;
				model[set_idx][c.way].ppn = c.ppn;
			end
		end
		default:
		begin
			// A flush rebuilds the boot map and drops every host entry
			r.status = tlb_cmd_pkg::ST_DONE;
			load_boot_map();
		end
		endcase
		return r;
	endfunction

	function automatic string status_text(input tlb_cmd_pkg::status_e s);
		case (s)
		tlb_cmd_pkg::ST_HIT: return "HIT";
		tlb_cmd_pkg::ST_MISS: return "MISS";
		tlb_cmd_pkg::ST_DONE: return "DONE";
		default: return "DENIED";
		endcase
	endfunction

	// Any address inside the 128 KiB ROM window
	function automatic logic [31:0] random_rom_addr();
		return 32'hFFF0_0000 + ($urandom % 32'h0002_0000);
	endfunction

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic add_step(input int i, input string name, input tlb_cmd_pkg::opcode_e op,
		input logic [31:0] va, input logic [18:0] ppn, input logic [2:0] rwx,
		input logic [1:0] way, input tlb_cmd_pkg::status_e st, input logic chk,
		input logic [31:0] pa);
		names[i] = name;
		steps[i].cmd.op = op;
		steps[i].cmd.vaddr = va;
		steps[i].cmd.ppn = ppn;
		steps[i].cmd.rwx = rwx;
		steps[i].cmd.way = way;
		steps[i].exp_status = st;
		steps[i].chk_paddr = chk;
		steps[i].exp_paddr = pa;
	endtask

	task automatic build_table();
		logic [31:0] va;
		add_step(0, "rom_base", tlb_cmd_pkg::OP_XLATE, 32'hFFF0_0000, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b1, 32'hFFF0_0000);
		// The ROM window is identity mapped, so paddr equals vaddr
		for (int i = 1; i <= 3; i++)
		begin
			va = random_rom_addr();
			add_step(i, $sformatf("rom_random_%0d", i), tlb_cmd_pkg::OP_XLATE, va, '0, '0,
				'0, tlb_cmd_pkg::ST_HIT, 1'b1, va);
		end
		add_step(4, "rom_top", tlb_cmd_pkg::OP_XLATE, 32'hFFF1_FFFC, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b1, 32'hFFF1_FFFC);
		add_step(5, "miss_low", tlb_cmd_pkg::OP_XLATE, 32'h0001_2344, '0, '0, '0,
			tlb_cmd_pkg::ST_MISS, 1'b0, '0);
		// Same set as the first ROM page but one tag higher
		add_step(6, "miss_above_rom", tlb_cmd_pkg::OP_XLATE, 32'hFFF2_0000, '0, '0, '0,
			tlb_cmd_pkg::ST_MISS, 1'b0, '0);
		add_step(7, "write_way2", tlb_cmd_pkg::OP_WRITE, 32'h1234_6000, 19'h0ABCD, 3'b011,
			2'd2, tlb_cmd_pkg::ST_DONE, 1'b0, '0);
		add_step(8, "hit_written", tlb_cmd_pkg::OP_XLATE, 32'h1234_6ABC, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b1, 32'h1579_AABC);
		add_step(9, "write_way0_denied", tlb_cmd_pkg::OP_WRITE, 32'hFFF0_6000, 19'h12345,
			3'b111, 2'd0, tlb_cmd_pkg::ST_DENIED, 1'b0, '0);
		add_step(10, "rom_after_deny", tlb_cmd_pkg::OP_XLATE, 32'hFFF0_6010, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b1, 32'hFFF0_6010);
		add_step(11, "write_way3", tlb_cmd_pkg::OP_WRITE, 32'h4000_2000, 19'h00777, 3'b110,
			2'd3, tlb_cmd_pkg::ST_DONE, 1'b0, '0);
		add_step(12, "hit_way3", tlb_cmd_pkg::OP_XLATE, 32'h4000_2004, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b0, '0);
		add_step(13, "flush", tlb_cmd_pkg::OP_FLUSH, '0, '0, '0, '0,
			tlb_cmd_pkg::ST_DONE, 1'b0, '0);
		add_step(14, "miss_after_flush", tlb_cmd_pkg::OP_XLATE, 32'h1234_6ABC, '0, '0, '0,
			tlb_cmd_pkg::ST_MISS, 1'b0, '0);
		add_step(15, "miss_way3_flushed", tlb_cmd_pkg::OP_XLATE, 32'h4000_2004, '0, '0, '0,
			tlb_cmd_pkg::ST_MISS, 1'b0, '0);
		va = random_rom_addr();
		add_step(16, "rom_after_flush", tlb_cmd_pkg::OP_XLATE, va, '0, '0, '0,
			tlb_cmd_pkg::ST_HIT, 1'b1, va);
		add_step(17, "rom_set3_after_flush", tlb_cmd_pkg::OP_XLATE, 32'hFFF0_7FFF, '0, '0,
			'0, tlb_cmd_pkg::ST_HIT, 1'b1, 32'hFFF0_7FFF);
	endtask

	// ==================================================
	// Four-phase handshake and checks
	// ==================================================

	task automatic run_step(input int i);
		tlb_cmd_pkg::tlb_resp_t exp_resp;
		step_errors = 0;
		exp_resp = predict(steps[i].cmd);
		// Command and req change together on the falling edge and are stable at the rising one
		cmd = steps[i].cmd;
		req = 1'b1;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		if (resp.status != steps[i].exp_status)
		begin
			$display("Error %s: status expected %s, actual %s", names[i],
				status_text(steps[i].exp_status), status_text(resp.status));
			step_errors++;
		end
		if (steps[i].chk_paddr && resp.paddr != steps[i].exp_paddr)
		begin
			$display("Error %s: paddr expected %h, actual %h", names[i],
				steps[i].exp_paddr, resp.paddr);
			step_errors++;
		end
		if (resp != exp_resp)
		begin
			$display("Error %s: resp expected %h, actual %h", names[i], exp_resp, resp);
			step_errors++;
		end
		// The host keeps req up, so ack and resp have to stay put
		repeat (HOLD_CYCLES)
		begin
			@(negedge clk);
			if (!ack)
			begin
				$display("%s: ack dropped while req was still high", names[i]);
				step_errors++;
			end
			if (resp != exp_resp)
			begin
				$display("Error %s: held resp expected %h, actual %h", names[i],
					exp_resp, resp);
				step_errors++;
			end
		end
		req = 1'b0;
		@(negedge clk);
		if (ack)
		begin
			$display("%s: ack still high one cycle after req fell", names[i]);
			step_errors++;
		end
		while (ack)
			@(negedge clk);
		if (step_errors == 0)
			pass_count++;
		else
			fail_count++;
		$display("%-22s %s", names[i], (step_errors == 0) ? "ok" : "failed");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		cmd = '0;
		pass_count = 0;
		fail_count = 0;
		step_errors = 0;
		void'($urandom(3));
		build_table();
		load_boot_map();
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// The port itself holds the first command back until the boot fill is over
		for (int i = 0; i < NUM_STEPS; i++)
			run_step(i);
		$display("Tests run: %0d, passed: %0d, failed: %0d", NUM_STEPS, pass_count,
			fail_count);
		if (fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Budget of 100 cycles per step plus room for reset and the boot fill
	initial
	begin
		#((NUM_STEPS * 100 + 200) * CLK_PERIOD);
		$display("Watchdog expired, the DUT stopped answering the handshake");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
